/* tb/cache_bank_patterns.hex */
// columns: test, op (0 fetch, 1 write), address, write data, expected fetch data, dram
// dram: bit 1 write-back expected, bit 0 fill expected, f leaves it unchecked
1001230000A4861
1045670000E0C21
2001230000A4860
2045670000E0C20
310123111100000
300123000011110
3189A3222200000
3089A3000022220
411009D00100000
412009D00200000
413009D00300000
414009D00400000
415009D00500002
4010090000D0013
5100A333330000F
5020090000D002F
5030090000D003F
51600944440000F
51700955550000F
5040090000D004F
5050090000D005F
50012300001111F
5000A300003333F
5089A300002222F
50BEEF00001B4AF
50600900004444F
50700900005555F
5045670000E0C2F
51BEEF66660000F
50BEEF00006666F
5010090000D001F
000000000000000

/* verilog.f */
+incdir+source
source/cache_bank_pkg.sv
source/way_store.sv
source/srrip_replacer.sv
source/bank_controller.sv
source/cache_bank.sv
tb/cache_bank_assertions.sv
tb/cache_bank_tb.sv

/* Makefile */
# Verilator build and run of the cache bank testbench

SOURCES := verilog.f $(wildcard source/*.sv source/*.svh tb/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vcache_bank_tb: $(SOURCES)
	verilator --binary --assert -Wno-fatal --top-module cache_bank_tb \
		-f verilog.f -o Vcache_bank_tb

run: obj_dir/Vcache_bank_tb
	./obj_dir/Vcache_bank_tb | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb/cache_bank_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_bank_params.svh"

module cache_bank_tb;

    localparam int WAIT_LIMIT = 200;
    localparam int PAT_DEPTH  = 64;

    logic                           i_clk;
    logic                           i_nreset;
    cache_bank_pkg::pe_req_t        i_req;
    logic                           i_req_valid;
    logic                           o_req_ready;
    logic [`CB_DATA_WIDTH-1:0]      o_pe_data;
    logic                           o_pe_valid;
    logic                           i_pe_ready;
    logic [`CB_ADDR_WIDTH-1:0]      o_dram_addr;
    logic [`CB_DATA_WIDTH-1:0]      o_dram_wb_data;
    logic                           o_dram_wb_valid;
    logic                           i_dram_wb_ready;
    logic [`CB_DATA_WIDTH-1:0]      i_dram_fill_data;
    logic                           i_dram_fill_valid;
    logic                           o_dram_fill_ready;

    // test, op, address, write data, expected fetch data, dram activity
    logic [59:0]                    patterns [PAT_DEPTH];
    logic [`CB_DATA_WIDTH-1:0]      dram_mem [65536];
    logic [`CB_DATA_WIDTH-1:0]      shadow   [65536];
    logic                           written  [65536];

    logic [31:0]                    rng;
    int                             wb_count;
    int                             fill_count;
    int                             resp_count;
    logic [`CB_DATA_WIDTH-1:0]      resp_data;
    int                             check_count;
    int                             error_count;
    int                             test_checks;
    int                             test_errors;
    logic                           timed_out;

    cache_bank i_dut (
        .i_clk             (i_clk),
        .i_nreset          (i_nreset),
        .i_req             (i_req),
        .i_req_valid       (i_req_valid),
        .o_req_ready       (o_req_ready),
        .o_pe_data         (o_pe_data),
        .o_pe_valid        (o_pe_valid),
        .i_pe_ready        (i_pe_ready),
        .o_dram_addr       (o_dram_addr),
        .o_dram_wb_data    (o_dram_wb_data),
        .o_dram_wb_valid   (o_dram_wb_valid),
        .i_dram_wb_ready   (i_dram_wb_ready),
        .i_dram_fill_data  (i_dram_fill_data),
        .i_dram_fill_valid (i_dram_fill_valid),
        .o_dram_fill_ready (o_dram_fill_ready)
    );

    always #50 i_clk = ~i_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd1:    return "cold fetch miss";
            4'd2:    return "repeated fetch hit";
            4'd3:    return "write then fetch";
            4'd4:    return "dirty eviction";
            default: return "random back-pressure";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        test_checks++;
        if (got !== expected) begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, expected);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic report_test(input logic [3:0] id);
        if (test_errors == 0) begin
            $display("test %0d (%s): ok, %0d checks", id, test_name(id), test_checks);
        end else begin
            $display("test %0d (%s): %0d of %0d checks wrong", id, test_name(id),
                     test_errors, test_checks);
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    // --------------------------------------------------
    // DRAM model and random back-pressure
    // --------------------------------------------------
    // handshakes seen here complete on the following rising edge
    always @(negedge i_clk) begin
        rng = xorshift32(rng);
        i_pe_ready        = (rng[1:0] != 2'b00);
        i_dram_wb_ready   = (rng[9:8] != 2'b00);
        i_dram_fill_valid = (rng[17:16] != 2'b00);
        i_dram_fill_data  = dram_mem[o_dram_addr];
        if (o_dram_wb_valid && i_dram_wb_ready) begin
            check_value("written address on write-back", 32'(written[o_dram_addr]), 32'd1);
            check_value("o_dram_wb_data", 32'(o_dram_wb_data), 32'(shadow[o_dram_addr]));
            dram_mem[o_dram_addr] = o_dram_wb_data;
            wb_count++;
        end
        if (o_dram_fill_ready && i_dram_fill_valid) begin
            fill_count++;
        end
        if (o_pe_valid && i_pe_ready) begin
            resp_count++;
            resp_data = o_pe_data;
        end
    end

    task automatic run_request(input logic [59:0] pat);
        logic                       is_write;
        logic [`CB_ADDR_WIDTH-1:0]  addr;
        logic [`CB_DATA_WIDTH-1:0]  data;
        logic [3:0]                 dram_flags;
        int                         cycles;
        is_write   = pat[52];
        addr       = pat[51:36];
        data       = pat[35:20];
        dram_flags = pat[3:0];

        cycles = 0;
        while (!o_req_ready && cycles < WAIT_LIMIT) begin
            @(negedge i_clk);
            cycles++;
        end
        if (!o_req_ready) begin
            $display("timeout: bank never became ready for the request to 0x%h", addr);
            timed_out = 1'b1;
            return;
        end

        wb_count   = 0;
        fill_count = 0;
        resp_count = 0;
        i_req.op    = is_write ? cache_bank_pkg::REQ_WRITE : cache_bank_pkg::REQ_FETCH;
        i_req.addr  = addr;
        i_req.data  = data;
        i_req_valid = 1'b1;
        @(negedge i_clk);
        // the request must have been taken by the lookup cycle
        check_value("o_req_ready in lookup", 32'(o_req_ready), 32'd0);

        // valid stays high so that a second acceptance would show up
        cycles = 0;
        while (!o_req_ready && cycles < WAIT_LIMIT) begin
            @(negedge i_clk);
            cycles++;
        end
        i_req_valid = 1'b0;
        if (!o_req_ready) begin
            $display("timeout: request to 0x%h never completed", addr);
            timed_out = 1'b1;
            return;
        end

        if (is_write) begin
            check_value("pe response count", resp_count, 0);
            shadow[addr]  = data;
            written[addr] = 1'b1;
        end else begin
            check_value("pe response count", resp_count, 1);
            check_value("o_pe_data", 32'(resp_data), 32'(pat[19:4]));
        end
        if (dram_flags != 4'hf) begin
            check_value("write-back count", wb_count, 32'(dram_flags[1]));
            check_value("fill count", fill_count, 32'(dram_flags[0]));
        end
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        int         idx;
        logic [3:0] cur_test;
        i_clk             = 1'b0;
        i_nreset          = 1'b0;
        i_req             = '0;
        i_req_valid       = 1'b0;
        i_pe_ready        = 1'b0;
        i_dram_wb_ready   = 1'b0;
        i_dram_fill_data  = '0;
        i_dram_fill_valid = 1'b0;
        rng               = 32'd55491;
        check_count       = 0;
        error_count       = 0;
        test_checks       = 0;
        test_errors       = 0;
        timed_out         = 1'b0;

        for (int a = 0; a < 65536; a++) begin
            dram_mem[a] = 16'(a) ^ 16'ha5a5;
            shadow[a]   = 16'(a) ^ 16'ha5a5;
            written[a]  = 1'b0;
        end
        for (int p = 0; p < PAT_DEPTH; p++) begin
            patterns[p] = '0;
        end
        $readmemh("tb/cache_bank_patterns.hex", patterns);

        repeat (5) @(negedge i_clk);
        i_nreset = 1'b1;
        @(negedge i_clk);

        cur_test = patterns[0][59:56];
        check_value("o_req_ready after reset", 32'(o_req_ready), 32'd1);

        idx = 0;
        while (idx < PAT_DEPTH && patterns[idx][59:56] != 4'h0 && !timed_out) begin
            if (patterns[idx][59:56] != cur_test) begin
                report_test(cur_test);
                cur_test = patterns[idx][59:56];
            end
            run_request(patterns[idx]);
            idx++;
        end
        report_test(cur_test);

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/cache_bank_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_bank_params.svh"

module cache_bank_assertions (
    input logic                         i_clk,
    input logic                         i_nreset,
    input logic                         i_req_ready,
    input logic                         i_pe_valid,
    input logic                         i_pe_ready,
    input logic [`CB_DATA_WIDTH-1:0]    i_pe_data,
    input logic                         i_wb_valid,
    input logic                         i_wb_ready,
    input logic [`CB_ADDR_WIDTH-1:0]    i_dram_addr,
    input logic [`CB_DATA_WIDTH-1:0]    i_wb_data,
    input logic                         i_fill_ready
);

    // --------------------------------------------------
    // one request in flight at a time
    // --------------------------------------------------
    a_busy_not_ready: assert property (@(posedge i_clk) disable iff (!i_nreset)
        (i_pe_valid || i_wb_valid || i_fill_ready) |-> !i_req_ready)
        else $error("request ready is high while a transfer is pending");

    a_one_transfer: assert property (@(posedge i_clk) disable iff (!i_nreset)
        $onehot0({i_pe_valid, i_wb_valid, i_fill_ready}))
        else $error("more than one of pe valid, write-back valid, fill ready");

    // offered transfers hold until taken
    a_pe_hold: assert property (@(posedge i_clk) disable iff (!i_nreset)
        (i_pe_valid && !i_pe_ready) |=> (i_pe_valid && $stable(i_pe_data)))
        else $error("pe response changed before it was taken");

    a_wb_hold: assert property (@(posedge i_clk) disable iff (!i_nreset)
        (i_wb_valid && !i_wb_ready) |=>
            (i_wb_valid && $stable(i_wb_data) && $stable(i_dram_addr)))
        else $error("write-back changed before it was taken");

endmodule

bind cache_bank cache_bank_assertions u_assertions (
    .i_clk        (i_clk),
    .i_nreset     (i_nreset),
    .i_req_ready  (o_req_ready),
    .i_pe_valid   (o_pe_valid),
    .i_pe_ready   (i_pe_ready),
    .i_pe_data    (o_pe_data),
    .i_wb_valid   (o_dram_wb_valid),
    .i_wb_ready   (i_dram_wb_ready),
    .i_dram_addr  (o_dram_addr),
    .i_wb_data    (o_dram_wb_data),
    .i_fill_ready (o_dram_fill_ready)
);

`default_nettype wire

/* source/cache_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_bank_params.svh"

module cache_bank (
    input  logic                        i_clk,
    input  logic                        i_nreset,
    input  cache_bank_pkg::pe_req_t     i_req,
    input  logic                        i_req_valid,
    output logic                        o_req_ready,
    output logic [`CB_DATA_WIDTH-1:0]   o_pe_data,
    output logic                        o_pe_valid,
    input  logic                        i_pe_ready,
    output logic [`CB_ADDR_WIDTH-1:0]   o_dram_addr,
    output logic [`CB_DATA_WIDTH-1:0]   o_dram_wb_data,
    output logic                        o_dram_wb_valid,
    input  logic                        i_dram_wb_ready,
    input  logic [`CB_DATA_WIDTH-1:0]   i_dram_fill_data,
    input  logic                        i_dram_fill_valid,
    output logic                        o_dram_fill_ready
);

    logic [`CB_SET_BITS-1:0]        set;
    logic [`CB_TAG_BITS-1:0]        tag;
    cache_bank_pkg::line_meta_t     way_meta [`CB_WAYS];
    logic [`CB_DATA_WIDTH-1:0]      way_data [`CB_WAYS];
    logic                           hit;
    logic [`CB_WAY_BITS-1:0]        hit_way;
    logic [`CB_WAY_BITS-1:0]        victim_way;
    logic                           victim_dirty;
    logic [`CB_TAG_BITS-1:0]        victim_tag;
    logic [`CB_RRPV_BITS-1:0]       rrpv_hit [`CB_WAYS];
    logic [`CB_RRPV_BITS-1:0]       rrpv_miss [`CB_WAYS];
    logic [`CB_RRPV_BITS-1:0]       next_rrpv [`CB_WAYS];
    cache_bank_pkg::way_write_t     store_write;

    // hit ages around the hit way, miss ages around the installed way
    always_comb begin
        for (int w = 0; w < `CB_WAYS; w++) begin
            next_rrpv[w] = hit ? rrpv_hit[w] : rrpv_miss[w];
        end
    end

    bank_controller u_ctrl (
        .i_clk             (i_clk),
        .i_nreset          (i_nreset),
        .i_req             (i_req),
        .i_req_valid       (i_req_valid),
        .o_req_ready       (o_req_ready),
        .o_pe_data         (o_pe_data),
        .o_pe_valid        (o_pe_valid),
        .i_pe_ready        (i_pe_ready),
        .o_dram_addr       (o_dram_addr),
        .o_dram_wb_data    (o_dram_wb_data),
        .o_dram_wb_valid   (o_dram_wb_valid),
        .i_dram_wb_ready   (i_dram_wb_ready),
        .i_dram_fill_data  (i_dram_fill_data),
        .i_dram_fill_valid (i_dram_fill_valid),
        .o_dram_fill_ready (o_dram_fill_ready),
        .o_set             (set),
        .o_tag             (tag),
        .i_way_data        (way_data),
        .i_hit             (hit),
        .i_hit_way         (hit_way),
        .i_victim_way      (victim_way),
        .i_victim_dirty    (victim_dirty),
        .i_victim_tag      (victim_tag),
        .o_write           (store_write)
    );

    way_store u_store (
        .i_clk       (i_clk),
        .i_nreset    (i_nreset),
        .i_set       (set),
        .i_write     (store_write),
        .i_next_rrpv (next_rrpv),
        .o_meta      (way_meta),
        .o_data      (way_data)
    );

    srrip_replacer u_repl (
        .i_meta         (way_meta),
        .i_tag          (tag),
        .o_hit          (hit),
        .o_hit_way      (hit_way),
        .o_victim_way   (victim_way),
        .o_victim_dirty (victim_dirty),
        .o_victim_tag   (victim_tag),
        .o_rrpv_hit     (rrpv_hit),
        .o_rrpv_miss    (rrpv_miss)
    );

endmodule

`default_nettype wire

/* source/bank_controller.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_bank_params.svh"

module bank_controller (
    input  logic                        i_clk,
    input  logic                        i_nreset,
    // PE crossbar
    input  cache_bank_pkg::pe_req_t     i_req,
    input  logic                        i_req_valid,
    output logic                        o_req_ready,
    output logic [`CB_DATA_WIDTH-1:0]   o_pe_data,
    output logic                        o_pe_valid,
    input  logic                        i_pe_ready,
    // DRAM crossbar
    output logic [`CB_ADDR_WIDTH-1:0]   o_dram_addr,
    output logic [`CB_DATA_WIDTH-1:0]   o_dram_wb_data,
    output logic                        o_dram_wb_valid,
    input  logic                        i_dram_wb_ready,
    input  logic [`CB_DATA_WIDTH-1:0]   i_dram_fill_data,
    input  logic                        i_dram_fill_valid,
    output logic                        o_dram_fill_ready,
    // store and replacer
    output logic [`CB_SET_BITS-1:0]     o_set,
    output logic [`CB_TAG_BITS-1:0]     o_tag,
    input  logic [`CB_DATA_WIDTH-1:0]   i_way_data [`CB_WAYS],
    input  logic                        i_hit,
    input  logic [`CB_WAY_BITS-1:0]     i_hit_way,
    input  logic [`CB_WAY_BITS-1:0]     i_victim_way,
    input  logic                        i_victim_dirty,
    input  logic [`CB_TAG_BITS-1:0]     i_victim_tag,
    output cache_bank_pkg::way_write_t  o_write
);

    cache_bank_pkg::bank_state_e    state_q;
    cache_bank_pkg::pe_req_t        req_q;
    logic [`CB_WAY_BITS-1:0]        victim_way_q;
    logic [`CB_TAG_BITS-1:0]        victim_tag_q;
    logic [`CB_DATA_WIDTH-1:0]      victim_data_q;
    logic [`CB_DATA_WIDTH-1:0]      pe_data_q;
    logic                           is_write;
    logic                           req_fire;
    logic                           wb_fire;
    logic                           fill_fire;
    logic                           pe_fire;

    // handshakes are all decoded from the state
    assign o_req_ready       = (state_q == cache_bank_pkg::ST_IDLE);
    assign o_dram_wb_valid   = (state_q == cache_bank_pkg::ST_WRITEBACK);
    assign o_dram_fill_ready = (state_q == cache_bank_pkg::ST_FILL);
    assign o_pe_valid        = (state_q == cache_bank_pkg::ST_RESPOND);

    assign req_fire  = i_req_valid & o_req_ready;
    assign wb_fire   = o_dram_wb_valid & i_dram_wb_ready;
    assign fill_fire = o_dram_fill_ready & i_dram_fill_valid;
    assign pe_fire   = o_pe_valid & i_pe_ready;

    assign is_write = (req_q.op == cache_bank_pkg::REQ_WRITE);
    assign o_set    = req_q.addr[`CB_SET_BITS-1:0];
    assign o_tag    = req_q.addr[`CB_ADDR_WIDTH-1:`CB_SET_BITS];

    // victim address during write-back, request address otherwise
    assign o_dram_addr = (state_q == cache_bank_pkg::ST_WRITEBACK) ?
                         {victim_tag_q, o_set} : req_q.addr;
    assign o_dram_wb_data = victim_data_q;
    assign o_pe_data      = pe_data_q;

    // --------------------------------------------------
    // request sequencing
    // --------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_nreset) begin
            state_q <= cache_bank_pkg::ST_IDLE;
        end else begin
            case (state_q)
                cache_bank_pkg::ST_IDLE: begin
                    if (req_fire) state_q <= cache_bank_pkg::ST_LOOKUP;
                end
                cache_bank_pkg::ST_LOOKUP: begin
                    if (i_hit) begin
                        state_q <= is_write ? cache_bank_pkg::ST_IDLE
                                            : cache_bank_pkg::ST_RESPOND;
                    end else if (i_victim_dirty) begin
                        state_q <= cache_bank_pkg::ST_WRITEBACK;
                    end else begin
                        state_q <= is_write ? cache_bank_pkg::ST_IDLE
                                            : cache_bank_pkg::ST_FILL;
                    end
                end
                cache_bank_pkg::ST_WRITEBACK: begin
                    if (wb_fire) begin
                        state_q <= is_write ? cache_bank_pkg::ST_IDLE
                                            : cache_bank_pkg::ST_FILL;
                    end
                end
                cache_bank_pkg::ST_FILL: begin
                    if (fill_fire) state_q <= cache_bank_pkg::ST_RESPOND;
                end
                cache_bank_pkg::ST_RESPOND: begin
                    if (pe_fire) state_q <= cache_bank_pkg::ST_IDLE;
                end
                default: state_q <= cache_bank_pkg::ST_IDLE;
            endcase
        end
    end

    // request, victim and response payload
    always_ff @(posedge i_clk) begin
        if (req_fire) req_q <= i_req;
        if (state_q == cache_bank_pkg::ST_LOOKUP) begin
            victim_way_q  <= i_victim_way;
            victim_tag_q  <= i_victim_tag;
            victim_data_q <= i_way_data[i_victim_way];
        end
        if (state_q == cache_bank_pkg::ST_LOOKUP && i_hit) begin
            pe_data_q <= i_way_data[i_hit_way];
        end else if (fill_fire) begin
            pe_data_q <= i_dram_fill_data;
        end
    end

    // --------------------------------------------------
    // store update, one per request
    // --------------------------------------------------
    always_comb begin
        o_write            = '0;
        o_write.meta.valid = 1'b1;
        o_write.meta.tag   = o_tag;
        o_write.data       = req_q.data;
        case (state_q)
            cache_bank_pkg::ST_LOOKUP: begin
                if (i_hit) begin
                    // fetch hit only ages the set
                    o_write.update_rrpv = 1'b1;
                    o_write.we          = is_write;
                    o_write.way         = i_hit_way;
                    o_write.meta.dirty  = 1'b1;
                end else if (is_write && !i_victim_dirty) begin
                    o_write.update_rrpv = 1'b1;
                    o_write.we          = 1'b1;
                    o_write.way         = i_victim_way;
                    o_write.meta.dirty  = 1'b1;
                    o_write.meta.rrpv   = `CB_RRPV_BITS'(2);
                end
            end
            cache_bank_pkg::ST_WRITEBACK: begin
                if (wb_fire && is_write) begin
                    o_write.update_rrpv = 1'b1;
                    o_write.we          = 1'b1;
                    o_write.way         = victim_way_q;
                    o_write.meta.dirty  = 1'b1;
                    o_write.meta.rrpv   = `CB_RRPV_BITS'(2);
                end
            end
            cache_bank_pkg::ST_FILL: begin
                if (fill_fire) begin
                    o_write.update_rrpv = 1'b1;
                    o_write.we          = 1'b1;
                    o_write.way         = victim_way_q;
                    o_write.meta.rrpv   = `CB_RRPV_BITS'(2);
                    o_write.data        = i_dram_fill_data;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* source/srrip_replacer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_bank_params.svh"

module srrip_replacer (
    input  cache_bank_pkg::line_meta_t  i_meta [`CB_WAYS],
    input  logic [`CB_TAG_BITS-1:0]     i_tag,
    output logic                        o_hit,
    output logic [`CB_WAY_BITS-1:0]     o_hit_way,
    output logic [`CB_WAY_BITS-1:0]     o_victim_way,
    output logic                        o_victim_dirty,
    output logic [`CB_TAG_BITS-1:0]     o_victim_tag,
    output logic [`CB_RRPV_BITS-1:0]    o_rrpv_hit [`CB_WAYS],
    output logic [`CB_RRPV_BITS-1:0]    o_rrpv_miss [`CB_WAYS]
);

    logic                       found_invalid;
    logic [`CB_WAY_BITS-1:0]    invalid_way;
    logic [`CB_RRPV_BITS-1:0]   max_rrpv;
    logic                       found_max;
    logic [`CB_WAY_BITS-1:0]    max_way;
    logic [`CB_RRPV_BITS-1:0]   rrpv_inc [`CB_WAYS];

    // hit detection, lowest matching way wins
    always_comb begin
        o_hit     = 1'b0;
        o_hit_way = '0;
        for (int w = 0; w < `CB_WAYS; w++) begin
            if (!o_hit && i_meta[w].valid && i_meta[w].tag == i_tag) begin
                o_hit     = 1'b1;
                o_hit_way = `CB_WAY_BITS'(w);
            end
        end
    end

    // --------------------------------------------------
    // victim is the first invalid way or else the first way with max rrpv
    // --------------------------------------------------
    always_comb begin
        found_invalid = 1'b0;
        invalid_way   = '0;
        max_rrpv      = '0;
        found_max     = 1'b0;
        max_way       = '0;
        for (int w = 0; w < `CB_WAYS; w++) begin
            if (!found_invalid && !i_meta[w].valid) begin
                found_invalid = 1'b1;
                invalid_way   = `CB_WAY_BITS'(w);
            end
            if (i_meta[w].rrpv > max_rrpv) begin
                max_rrpv = i_meta[w].rrpv;
            end
        end
        for (int w = 0; w < `CB_WAYS; w++) begin
            if (!found_max && i_meta[w].rrpv == max_rrpv) begin
                found_max = 1'b1;
                max_way   = `CB_WAY_BITS'(w);
            end
        end
        o_victim_way = found_invalid ? invalid_way : max_way;
    end

    assign o_victim_dirty = i_meta[o_victim_way].valid & i_meta[o_victim_way].dirty;
    assign o_victim_tag   = i_meta[o_victim_way].tag;

    // candidate rrpv vectors for the controller to pick from
    always_comb begin
        for (int w = 0; w < `CB_WAYS; w++) begin
            // saturating increment
            rrpv_inc[w] = (i_meta[w].rrpv == '1) ? i_meta[w].rrpv : i_meta[w].rrpv + 1'b1;

            if (o_hit && o_hit_way == `CB_WAY_BITS'(w)) begin
                o_rrpv_hit[w] = '0;
            end else if (i_meta[w].valid) begin
                o_rrpv_hit[w] = rrpv_inc[w];
            end else begin
                o_rrpv_hit[w] = i_meta[w].rrpv;
            end

            // installed line starts at long re-reference interval
            if (o_victim_way == `CB_WAY_BITS'(w)) begin
                o_rrpv_miss[w] = `CB_RRPV_BITS'(2);
            end else begin
                o_rrpv_miss[w] = rrpv_inc[w];
            end
        end
    end

endmodule

`default_nettype wire

/* source/way_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_bank_params.svh"

module way_store (
    input  logic                        i_clk,
    input  logic                        i_nreset,
    input  logic [`CB_SET_BITS-1:0]     i_set,
    input  cache_bank_pkg::way_write_t  i_write,
    input  logic [`CB_RRPV_BITS-1:0]    i_next_rrpv [`CB_WAYS],
    output cache_bank_pkg::line_meta_t  o_meta [`CB_WAYS],
    output logic [`CB_DATA_WIDTH-1:0]   o_data [`CB_WAYS]
);

    // --------------------------------------------------
    // storage arrays, indexed [set][way]
    // --------------------------------------------------
    logic [`CB_WAYS-1:0]        valid_q [`CB_SETS];
    logic [`CB_WAYS-1:0]        dirty_q [`CB_SETS];
    logic [`CB_RRPV_BITS-1:0]   rrpv_q  [`CB_SETS][`CB_WAYS];
    logic [`CB_TAG_BITS-1:0]    tag_q   [`CB_SETS][`CB_WAYS];
    logic [`CB_DATA_WIDTH-1:0]  data_q  [`CB_SETS][`CB_WAYS];

    // valid bits clear on reset
    always_ff @(posedge i_clk) begin
        if (!i_nreset) begin
            for (int s = 0; s < `CB_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (i_write.we) begin
            valid_q[i_set][i_write.way] <= i_write.meta.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_write.we) begin
            dirty_q[i_set][i_write.way] <= i_write.meta.dirty;
            tag_q[i_set][i_write.way]   <= i_write.meta.tag;
            data_q[i_set][i_write.way]  <= i_write.data;
        end
        // whole-set aging from the replacer wins over the single way value
        if (i_write.update_rrpv) begin
            for (int w = 0; w < `CB_WAYS; w++) begin
                rrpv_q[i_set][w] <= i_next_rrpv[w];
            end
        end else if (i_write.we) begin
            rrpv_q[i_set][i_write.way] <= i_write.meta.rrpv;
        end
    end

    // combinational read of the addressed set
    always_comb begin
        for (int w = 0; w < `CB_WAYS; w++) begin
            o_meta[w].valid = valid_q[i_set][w];
            o_meta[w].dirty = dirty_q[i_set][w];
            o_meta[w].rrpv  = rrpv_q[i_set][w];
            o_meta[w].tag   = tag_q[i_set][w];
            o_data[w]       = data_q[i_set][w];
        end
    end

endmodule

`default_nettype wire

/* source/cache_bank_pkg.sv */
`default_nettype none

`include "cache_bank_params.svh"

package cache_bank_pkg;

    typedef enum logic {
        REQ_FETCH = 1'b0,
        REQ_WRITE = 1'b1
    } req_op_e;

    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_LOOKUP    = 3'd1,
        ST_WRITEBACK = 3'd2,
        ST_FILL      = 3'd3,
        ST_RESPOND   = 3'd4
    } bank_state_e;

    // request from the PE crossbar
    typedef struct packed {
        req_op_e                    op;
        logic [`CB_ADDR_WIDTH-1:0]  addr;
        logic [`CB_DATA_WIDTH-1:0]  data;
    } pe_req_t;

    typedef struct packed {
        logic                       valid;
        logic                       dirty;
        logic [`CB_RRPV_BITS-1:0]   rrpv;
        logic [`CB_TAG_BITS-1:0]    tag;
    } line_meta_t;

    // one update of the way store
    typedef struct packed {
        logic                       we;
        logic [`CB_WAY_BITS-1:0]    way;
        line_meta_t                 meta;
        logic [`CB_DATA_WIDTH-1:0]  data;
        logic                       update_rrpv;
    } way_write_t;

endpackage

`default_nettype wire

/* source/cache_bank_params.svh */
`ifndef CACHE_BANK_PARAMS_SVH
`define CACHE_BANK_PARAMS_SVH

// --------------------------------------------------
// geometry of one cache bank
// --------------------------------------------------

// word address, one word per line
`define CB_ADDR_WIDTH 16
`define CB_DATA_WIDTH 16

`define CB_SETS 16
`define CB_WAYS 4

// re-reference prediction value width
`define CB_RRPV_BITS 2

// derived widths
`define CB_SET_BITS ($clog2(`CB_SETS))
`define CB_WAY_BITS ($clog2(`CB_WAYS))
`define CB_TAG_BITS (`CB_ADDR_WIDTH - `CB_SET_BITS)

`endif
